//--- files.f
+incdir+test
hw/lease_pkg.sv
hw/lease_table.sv
hw/lease_line.sv
hw/victim_select.sv
hw/cache_controller.sv
hw/lease_cache_top.sv
test/tb_lease_cache.sv

//--- test/lease_cache_tests.svh
// reset the DUT and the reference state
task automatic apply_reset();
	resetn_i = 1'b0;
	repeat (5) @(posedge clock_i);
	#1;
	resetn_i = 1'b1;
	for (int i = 0; i < LINES; i++) begin
		m_valid[i] = 1'b0;
		m_lease[i] = '0;
	end
	for (int i = 0; i < TABLE_ENTRIES; i++) begin
		t_valid[i] = 1'b0;
	end
endtask

task automatic write_lease(input int idx, input tag_t tag, input lease_t lease);
	@(posedge clock_i);
	#1;
	cfg_wr_i    = 1'b1;
	cfg_idx_i   = TABLE_W'(idx);
	cfg_tag_i   = tag;
	cfg_lease_i = lease;
	@(posedge clock_i);
	#1;
	cfg_wr_i     = 1'b0;
	t_valid[idx] = 1'b1;
	t_tag[idx]   = tag;
	t_lease[idx] = lease;
endtask

// lowest valid matching entry wins, else the default
function automatic lease_t table_lease(tag_t t);
	for (int i = 0; i < TABLE_ENTRIES; i++) begin
		if (t_valid[i] && t_tag[i] == t) begin
			return t_lease[i];
		end
	end
	return DEFAULT_LEASE;
endfunction

function automatic int smallest_lease_line();
	int best;
	best = 0;
	for (int i = 1; i < LINES; i++) begin
		if (m_lease[i] < m_lease[best]) begin
			best = i;                      // ties keep the lower line
		end
	end
	return best;
endfunction

// step the lease model by one access, returns the expected expired flag
function automatic logic predict_access(tag_t t, int kind);
	lease_t l;
	int     victim;
	logic   any_exp;
	l       = table_lease(t);
	victim  = -1;
	any_exp = 1'b0;
	for (int i = 0; i < LINES; i++) begin
		if (!m_valid[i] || m_lease[i] == '0) begin
			any_exp = 1'b1;
			if (victim < 0) begin
				victim = i;
			end
		end
	end
	if (victim < 0) begin
		victim = smallest_lease_line();
	end
	for (int i = 0; i < LINES; i++) begin
		if (m_valid[i] && kind == K_HIT && m_tag[i] == t) begin
			m_lease[i] = l;                // renewed
		end else if (m_valid[i] && m_lease[i] != '0) begin
			m_lease[i] = m_lease[i] - 1'b1;
		end
	end
	if (kind == K_MISS) begin
		m_valid[victim] = 1'b1;
		m_tag[victim]   = t;
		m_lease[victim] = l;
	end
	return any_exp && (kind == K_MISS);
endfunction

// one read, checked against the expected outcome and the model
task automatic read_check(input string name, input addr_t a, input int kind);
	logic       exp_expired;
	logic [2:0] exp_flags;
	addr_t      exp_addr;
	int         cycles;
	int         reqs_before;
	exp_expired = predict_access(a[ADDR_W-1:OFFSET_W], kind);
	exp_flags   = (kind == K_HIT) ? 3'b100 : (kind == K_MISS) ? 3'b010 : 3'b001;
	exp_addr    = (kind == K_MISS) ? {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}} : a;
	reqs_before = mem_reqs;
	@(posedge clock_i);
	#1;
	req_i  = 1'b1;
	addr_i = a;
	cycles = 0;
	do begin
		@(posedge clock_i);
		#1;
		req_i = 1'b0;                      // strobe lasts one cycle
		cycles++;
	end while (!done_o && cycles < TIMEOUT);
	if (!done_o) begin
		$display("%s: no done_o within %0d cycles for address %h", name, TIMEOUT, a);
		timeouts++;
		return;
	end
	if ({flag_hit_o, flag_miss_o, flag_bypass_o} !== exp_flags) begin
		$display("ERR %s hit/miss/bypass expected %b actual %b", name, exp_flags,
			{flag_hit_o, flag_miss_o, flag_bypass_o});
		errors++;
	end
	if (flag_expired_o !== exp_expired) begin
		$display("ERR %s expired expected %b actual %b", name, exp_expired, flag_expired_o);
		errors++;
	end
	if (data_o !== mem_word(a)) begin
		$display("ERR %s data expected %h actual %h", name, mem_word(a), data_o);
		errors++;
	end
	if (kind == K_HIT && cycles != 2) begin
		$display("ERR %s hit latency expected 2 actual %0d", name, cycles);
		errors++;
	end
	if (mem_reqs - reqs_before != ((kind == K_HIT) ? 0 : 1)) begin
		$display("ERR %s memory requests expected %0d actual %0d", name,
			(kind == K_HIT) ? 0 : 1, mem_reqs - reqs_before);
		errors++;
	end
	if (kind != K_HIT && (last_block !== (kind == K_MISS) || last_addr !== exp_addr)) begin
		$display("ERR %s memory block/addr expected %b %h actual %b %h", name,
			kind == K_MISS, exp_addr, last_block, last_addr);
		errors++;
	end
endtask

// directed tests
// ----------------------------------------
task automatic miss_then_hit();
	apply_reset();
	read_check("miss_then_hit", 16'h0040, K_MISS);   // default lease
	read_check("miss_then_hit", 16'h0042, K_HIT);
endtask

task automatic zero_lease_bypass();
	apply_reset();
	write_lease(0, 14'h020, 8'd0);
	read_check("zero_lease_bypass", 16'h0081, K_BYPASS);
	read_check("zero_lease_bypass", 16'h0081, K_BYPASS);   // still not cached
endtask

task automatic fill_invalid_lines();
	apply_reset();
	for (int i = 0; i < LINES; i++) begin
		write_lease(i, tag_t'(14'h030 + i), 8'd20);
	end
	for (int i = 0; i < LINES; i++) begin
		read_check("fill_invalid_lines", addr_t'(16'h00C0 + 4 * i), K_MISS);
	end
	for (int i = 0; i < LINES; i++) begin
		read_check("fill_invalid_lines", addr_t'(16'h00C0 + 5 * i), K_HIT);
	end
endtask

task automatic expired_victim();
	apply_reset();
	write_lease(0, 14'h040, 8'd1);          // runs out after one other access
	for (int i = 1; i < LINES; i++) begin
		write_lease(i, tag_t'(14'h040 + i), 8'd30);
	end
	for (int i = 1; i < LINES; i++) begin
		read_check("expired_victim", addr_t'(16'h0100 + 4 * i), K_MISS);
	end
	read_check("expired_victim", 16'h0100, K_MISS);   // short lease block in the last line
	read_check("expired_victim", 16'h0104, K_HIT);    // counts it down to zero
	read_check("expired_victim", 16'h0200, K_MISS);   // all lines valid here
	if (flag_expired_o !== 1'b1) begin
		$display("ERR expired_victim evict flag expected 1 actual %b", flag_expired_o);
		errors++;
	end
	for (int i = 1; i < LINES; i++) begin
		read_check("expired_victim", addr_t'(16'h0100 + 4 * i), K_HIT);
	end
	read_check("expired_victim", 16'h0102, K_MISS);   // first block was evicted
endtask

task automatic min_lease_eviction();
	tag_t victim_tag;
	apply_reset();
	write_lease(0, 14'h050, 8'd9);
	write_lease(1, 14'h051, 8'd7);
	write_lease(2, 14'h052, 8'd8);
	write_lease(3, 14'h053, 8'd10);
	for (int i = 0; i < LINES; i++) begin
		read_check("min_lease_eviction", addr_t'(16'h0140 + 4 * i), K_MISS);
	end
	victim_tag = m_tag[smallest_lease_line()];   // all leases still above zero
	read_check("min_lease_eviction", 16'h0300, K_MISS);
	if (flag_expired_o !== 1'b0) begin
		$display("ERR min_lease_eviction evict flag expected 0 actual %b", flag_expired_o);
		errors++;
	end
	read_check("min_lease_eviction", {victim_tag, 2'b01}, K_MISS);
endtask

//--- test/tb_lease_cache.sv
`timescale 1ns/1ps

module tb_lease_cache
	import lease_pkg::*;
();

	localparam int TIMEOUT  = 50;      // cycles allowed for one wait
	localparam int K_HIT    = 0;       // expected outcome of a read
	localparam int K_MISS   = 1;
	localparam int K_BYPASS = 2;

	logic               clock_i, resetn_i;
	logic               req_i, cfg_wr_i, mem_valid_i;
	addr_t              addr_i;
	logic [TABLE_W-1:0] cfg_idx_i;
	tag_t               cfg_tag_i;
	lease_t             cfg_lease_i;
	data_t              mem_data_i;
	logic               done_o, flag_hit_o, flag_miss_o, flag_bypass_o, flag_expired_o;
	logic               mem_req_o, mem_block_o;
	data_t              data_o;
	addr_t              mem_addr_o;

	integer seed     = 32'h9ae5_1967;  // memory spacing
	int     errors   = 0;
	int     timeouts = 0;
	int     mem_reqs = 0;              // requests seen by the memory model
	logic   last_block;
	addr_t  last_addr;

	// reference state of lines and table
	logic   m_valid [LINES];
	tag_t   m_tag   [LINES];
	lease_t m_lease [LINES];
	logic   t_valid [TABLE_ENTRIES];
	tag_t   t_tag   [TABLE_ENTRIES];
	lease_t t_lease [TABLE_ENTRIES];

	lease_cache_top dut (.*);

	// fixed data pattern of the backing memory
	function automatic data_t mem_word(addr_t a);
		return data_t'(a) * 32'd3 + 32'h1000_0000;
	endfunction

	`include "lease_cache_tests.svh"

	initial begin
		clock_i = 1'b0;
		forever #5 clock_i = ~clock_i;     // 10 ns period
	end

	// memory model
	// ----------------------------------------
	initial begin : memory_model
		int    n;
		int    gap;
		addr_t base;

		mem_valid_i = 1'b0;
		mem_data_i  = '0;
		forever begin
			@(posedge clock_i);
			#1;
			if (mem_req_o) begin
				mem_reqs++;
				last_block = mem_block_o;
				last_addr  = mem_addr_o;
				base       = mem_addr_o;
				n          = mem_block_o ? BLOCK_WORDS : 1;
				for (int w = 0; w < n; w++) begin
					gap = 1 + ($unsigned($random(seed)) % 3);   // 1 to 3 cycles
					repeat (gap) @(posedge clock_i);
					#1;
					mem_valid_i = 1'b1;
					mem_data_i  = mem_word(base + addr_t'(w));
					@(posedge clock_i);
					#1;
					mem_valid_i = 1'b0;
				end
			end
		end
	end

	// test sequence
	// ----------------------------------------
	initial begin
		resetn_i    = 1'b0;
		req_i       = 1'b0;
		addr_i      = '0;
		cfg_wr_i    = 1'b0;
		cfg_idx_i   = '0;
		cfg_tag_i   = '0;
		cfg_lease_i = '0;
		miss_then_hit();
		zero_lease_bypass();
		fill_invalid_lines();
		expired_victim();
		min_lease_eviction();
		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- hw/lease_cache_top.sv
`timescale 1ns/1ps

module lease_cache_top
	import lease_pkg::*;
(
	input  logic               clock_i,
	input  logic               resetn_i,
	// requester
	input  logic               req_i,
	input  addr_t              addr_i,
	output logic               done_o,
	output data_t              data_o,
	output logic               flag_hit_o,
	output logic               flag_miss_o,
	output logic               flag_bypass_o,
	output logic               flag_expired_o,
	// lease table configuration
	input  logic               cfg_wr_i,
	input  logic [TABLE_W-1:0] cfg_idx_i,
	input  tag_t               cfg_tag_i,
	input  lease_t             cfg_lease_i,
	// memory
	output logic               mem_req_o,
	output logic               mem_block_o,
	output addr_t              mem_addr_o,
	input  logic               mem_valid_i,
	input  data_t              mem_data_i
);

	tag_t             look_tag;
	lease_t           look_lease;
	logic             access, install, any_hit, victim_expired;
	line_idx_t        install_line, hit_line, victim_line;
	logic [LINES-1:0] hit_vec, expired_vec;
	lease_t           line_lease [LINES];

	lease_table u_table (
		.clock_i, .resetn_i, .cfg_wr_i, .cfg_idx_i, .cfg_tag_i, .cfg_lease_i,
		.look_tag_i(look_tag), .look_lease_o(look_lease));

	// one line per way, install decoded per line
	for (genvar g = 0; g < LINES; g++) begin : g_line
		lease_line u_line (
			.clock_i, .resetn_i,
			.look_tag_i(look_tag), .access_i(access),
			.install_i(install && (install_line == line_idx_t'(g))),
			.lease_i(look_lease), .install_tag_i(look_tag),
			.hit_o(hit_vec[g]), .expired_o(expired_vec[g]), .lease_o(line_lease[g]));
	end

	victim_select u_victim (
		.hit_vec_i(hit_vec), .expired_vec_i(expired_vec), .lease_vec_i(line_lease),
		.any_hit_o(any_hit), .hit_line_o(hit_line),
		.victim_line_o(victim_line), .victim_expired_o(victim_expired));

	cache_controller u_ctrl (
		.clock_i, .resetn_i, .req_i, .addr_i, .done_o, .data_o,
		.flag_hit_o, .flag_miss_o, .flag_bypass_o, .flag_expired_o,
		.look_tag_o(look_tag), .look_lease_i(look_lease), .access_o(access),
		.install_o(install), .install_line_o(install_line),
		.any_hit_i(any_hit), .hit_line_i(hit_line), .victim_line_i(victim_line),
		.victim_expired_i(victim_expired),
		.mem_req_o, .mem_block_o, .mem_addr_o, .mem_valid_i, .mem_data_i);

endmodule

//--- hw/cache_controller.sv
`timescale 1ns/1ps

module cache_controller
	import lease_pkg::*;
(
	input  logic      clock_i,
	input  logic      resetn_i,

	// requester
	input  logic      req_i,            // one-cycle strobe
	input  addr_t     addr_i,
	output logic      done_o,
	output data_t     data_o,
	output logic      flag_hit_o,
	output logic      flag_miss_o,
	output logic      flag_bypass_o,
	output logic      flag_expired_o,

	// lease table and lines
	output tag_t      look_tag_o,
	input  lease_t    look_lease_i,
	output logic      access_o,
	output logic      install_o,
	output line_idx_t install_line_o,
	input  logic      any_hit_i,
	input  line_idx_t hit_line_i,
	input  line_idx_t victim_line_i,
	input  logic      victim_expired_i,

	// memory
	output logic      mem_req_o,
	output logic      mem_block_o,
	output addr_t     mem_addr_o,
	input  logic      mem_valid_i,
	input  data_t     mem_data_i
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_HIT_READ,     // done cycle of a hit, array read out
		ST_FILL,
		ST_BYPASS
	} state_t;

	state_t    state_q;
	addr_t     addr_q;               // registered request
	line_idx_t line_q;               // hit line or fill victim
	lease_t    lease_q;              // lease seen at lookup
	logic      vexp_q;               // victim was expired at lookup
	offset_t   cnt_q;                // fill word counter
	data_t     word_q;               // requested word on a miss
	data_t     data_mem [LINES][BLOCK_WORDS];
	logic      done_q, hit_q, miss_q, bypass_q, exp_q;
	logic      install_q, mem_req_q, mem_block_q;
	addr_t     mem_addr_q;
	tag_t      req_tag;
	offset_t   req_off;
	logic      accept;

	assign req_tag = addr_q[ADDR_W-1:OFFSET_W];
	assign req_off = addr_q[OFFSET_W-1:0];
	assign accept  = req_i && (state_q == ST_IDLE || state_q == ST_HIT_READ);

	// sequencing
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q   <= ST_IDLE;
			cnt_q     <= '0;
			done_q    <= 1'b0;
			hit_q     <= 1'b0;
			miss_q    <= 1'b0;
			bypass_q  <= 1'b0;
			exp_q     <= 1'b0;
			install_q <= 1'b0;
			mem_req_q <= 1'b0;
		end else begin
			// strobes default low
			done_q    <= 1'b0;
			hit_q     <= 1'b0;
			miss_q    <= 1'b0;
			bypass_q  <= 1'b0;
			exp_q     <= 1'b0;
			install_q <= 1'b0;
			mem_req_q <= 1'b0;
			case (state_q)
				ST_IDLE, ST_HIT_READ: begin
					state_q <= accept ? ST_LOOKUP : ST_IDLE;
				end
				ST_LOOKUP: begin
					if (any_hit_i) begin
						done_q  <= 1'b1;            // 2 cycles after req_i
						hit_q   <= 1'b1;
						state_q <= ST_HIT_READ;
					end else if (look_lease_i == '0) begin
						mem_req_q <= 1'b1;          // single word, not cached
						state_q   <= ST_BYPASS;
					end else begin
						mem_req_q <= 1'b1;          // whole block
						cnt_q     <= '0;
						state_q   <= ST_FILL;
					end
				end
				ST_FILL: begin
					if (mem_valid_i) begin
						cnt_q <= cnt_q + offset_t'(1);
						if (cnt_q == offset_t'(BLOCK_WORDS - 1)) begin
							done_q    <= 1'b1;
							miss_q    <= 1'b1;
							exp_q     <= vexp_q;
							install_q <= 1'b1;      // line takes tag and lease now
							state_q   <= ST_IDLE;
						end
					end
				end
				ST_BYPASS: begin
					if (mem_valid_i) begin
						done_q   <= 1'b1;
						bypass_q <= 1'b1;
						state_q  <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// request payload and data array
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (accept) begin
			addr_q <= addr_i;
		end
		if (state_q == ST_LOOKUP) begin
			line_q      <= any_hit_i ? hit_line_i : victim_line_i;
			lease_q     <= look_lease_i;
			vexp_q      <= victim_expired_i;
			mem_block_q <= (look_lease_i != '0);
			mem_addr_q  <= (look_lease_i != '0) ? {req_tag, {OFFSET_W{1'b0}}} : addr_q;
		end
		if (mem_valid_i && state_q == ST_BYPASS) begin
			word_q <= mem_data_i;
		end
		if (mem_valid_i && state_q == ST_FILL) begin
			data_mem[line_q][cnt_q] <= mem_data_i;   // words come in order
			if (cnt_q == req_off) begin
				word_q <= mem_data_i;                // requested word
			end
		end
	end

	assign look_tag_o     = req_tag;
	assign access_o       = (state_q == ST_LOOKUP);
	assign install_o      = install_q;
	assign install_line_o = line_q;
	assign done_o         = done_q;
	assign data_o         = (state_q == ST_HIT_READ) ? data_mem[line_q][req_off] : word_q;
	assign flag_hit_o     = hit_q;
	assign flag_miss_o    = miss_q;
	assign flag_bypass_o  = bypass_q;
	assign flag_expired_o = exp_q;
	assign mem_req_o      = mem_req_q;
	assign mem_block_o    = mem_block_q;
	assign mem_addr_o     = mem_addr_q;

	// one block request in flight until its install
	a_no_req_in_fill: assert property (@(posedge clock_i) disable iff (!resetn_i)
		(mem_req_o && mem_block_o) |=> (!mem_req_o until_with install_o));

	// table stays put while a fill is outstanding, so the line gets the lookup lease
	a_install_lease: assert property (@(posedge clock_i) disable iff (!resetn_i)
		install_o |-> (look_lease_i == lease_q));

endmodule

//--- hw/victim_select.sv
`timescale 1ns/1ps

module victim_select
	import lease_pkg::*;
(
	input  logic [LINES-1:0] hit_vec_i,
	input  logic [LINES-1:0] expired_vec_i,
	input  lease_t           lease_vec_i [LINES],

	output logic             any_hit_o,
	output line_idx_t        hit_line_o,
	output line_idx_t        victim_line_o,
	output logic             victim_expired_o  // victim was invalid or expired
);

	// hit encoder
	// ----------------------------------------
	always_comb begin
		any_hit_o  = |hit_vec_i;
		hit_line_o = '0;
		for (int i = LINES - 1; i >= 0; i--) begin
			if (hit_vec_i[i]) begin
				hit_line_o = line_idx_t'(i);
			end
		end
	end

	// victim choice
	// ----------------------------------------
	always_comb begin : pick
		line_idx_t exp_line;         // lowest expired line
		line_idx_t min_line;         // lowest line at minimum lease
		lease_t    min_lease;

		exp_line  = '0;
		min_line  = '0;
		min_lease = lease_vec_i[0];
		for (int i = LINES - 1; i >= 0; i--) begin
			if (expired_vec_i[i]) begin
				exp_line = line_idx_t'(i);
			end
		end
		for (int i = 1; i < LINES; i++) begin
			if (lease_vec_i[i] < min_lease) begin  // strict, ties keep lower index
				min_lease = lease_vec_i[i];
				min_line  = line_idx_t'(i);
			end
		end
		victim_expired_o = |expired_vec_i;
		victim_line_o    = victim_expired_o ? exp_line : min_line;
	end

	// tags are unique across lines, so at most one hits
	always_comb begin
		if (!$isunknown(hit_vec_i)) begin
			a_one_hit: assert #0 ($onehot0(hit_vec_i))
				else $error("more than one line hit");
		end
	end

endmodule

//--- hw/lease_line.sv
`timescale 1ns/1ps

module lease_line
	import lease_pkg::*;
(
	input  logic   clock_i,
	input  logic   resetn_i,

	// lookup side, shared by all lines
	input  tag_t   look_tag_i,
	input  logic   access_i,       // high in the lookup cycle
	input  logic   install_i,      // only for the selected line
	input  lease_t lease_i,        // lease from the table
	input  tag_t   install_tag_i,

	// status towards victim_select
	output logic   hit_o,
	output logic   expired_o,
	output lease_t lease_o
);

	logic   valid_q;
	tag_t   tag_q;
	lease_t lease_q;               // remaining lease

	assign hit_o     = valid_q && (tag_q == look_tag_i);
	assign expired_o = !valid_q || (lease_q == '0);   // free to evict
	assign lease_o   = lease_q;

	// valid bit, set once filled
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= 1'b0;
		end else if (install_i) begin
			valid_q <= 1'b1;
		end
	end

	// lease countdown
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			lease_q <= '0;
		end else if (install_i) begin
			lease_q <= lease_i;                    // fresh block
		end else if (access_i) begin
			if (hit_o) begin
				lease_q <= lease_i;                // renew on hit
			end else if (valid_q && lease_q != '0) begin
				lease_q <= lease_q - lease_t'(1);  // saturates at zero
			end
		end
	end

	// tag of the resident block
	always_ff @(posedge clock_i) begin
		if (install_i) begin
			tag_q <= install_tag_i;
		end
	end

	// controller installs only after the lookup is over
	a_no_install_on_access: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(install_i && access_i));

endmodule

//--- hw/lease_table.sv
`timescale 1ns/1ps

module lease_table
	import lease_pkg::*;
(
	input  logic               clock_i,
	input  logic               resetn_i,

	// configuration write port
	input  logic               cfg_wr_i,     // one-cycle strobe
	input  logic [TABLE_W-1:0] cfg_idx_i,
	input  tag_t               cfg_tag_i,
	input  lease_t             cfg_lease_i,

	// lookup port
	input  tag_t               look_tag_i,
	output lease_t             look_lease_o  // combinational answer
);

	logic [TABLE_ENTRIES-1:0] valid_q;       // entry holds a tag
	tag_t                     tag_q   [TABLE_ENTRIES];
	lease_t                   lease_q [TABLE_ENTRIES];
	logic [TABLE_ENTRIES-1:0] match;

	// entry valid bits
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;                   // table empty after reset
		end else if (cfg_wr_i) begin
			valid_q[cfg_idx_i] <= 1'b1;
		end
	end

	// entry contents
	always_ff @(posedge clock_i) begin
		if (cfg_wr_i) begin
			tag_q[cfg_idx_i]   <= cfg_tag_i;
			lease_q[cfg_idx_i] <= cfg_lease_i;
		end
	end

	// lookup
	// ----------------------------------------
	always_comb begin
		for (int i = 0; i < TABLE_ENTRIES; i++) begin
			match[i] = valid_q[i] && (tag_q[i] == look_tag_i);
		end
	end

	// scan downward so the lowest matching entry is the last to write
	always_comb begin
		look_lease_o = DEFAULT_LEASE;       // unknown tag
		for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
			if (match[i]) begin
				look_lease_o = lease_q[i];
			end
		end
	end

endmodule

//--- hw/lease_pkg.sv
package lease_pkg;

	// address layout
	// ----------------------------------------
	localparam int ADDR_W        = 16;               // word address
	localparam int OFFSET_W      = 2;                // word within block
	localparam int BLOCK_WORDS   = 1 << OFFSET_W;    // 4 words per block
	localparam int TAG_W         = ADDR_W - OFFSET_W;

	// cache geometry
	// ----------------------------------------
	localparam int LINES         = 4;                // fully associative
	localparam int LINE_W        = 2;
	localparam int LEASE_W       = 8;
	localparam int TABLE_ENTRIES = 8;                // lease table size
	localparam int TABLE_W       = 3;
	localparam int DATA_W        = 32;

	// common types
	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [LEASE_W-1:0]  lease_t;
	typedef logic [LINE_W-1:0]   line_idx_t;
	typedef logic [DATA_W-1:0]   data_t;

	// lease for a tag the table does not know
	localparam lease_t DEFAULT_LEASE = 8'd2;

endpackage
